//--- files.f
src/bomb_pkg.sv
src/button_sync.sv
src/countdown_timer.sv
src/lfsr_rand.sv
src/arrow_puzzle.sv
src/game_control_fsm.sv
src/bomb_game_top.sv
dv/bomb_game_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it.
# The exit status is that of the simulation.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f files.f \
    --top-module bomb_game_tb \
    --Mdir obj_dir \
    -o bomb_game_sim

./obj_dir/bomb_game_sim

//--- dv/bomb_game_tb.sv
module bomb_game_tb;

    // --------------------
    // Test length and timeout
    // --------------------

    localparam int PRESS_CYCLES   = 12;                  // Six cycles held and six released
    localparam int MAX_GAP        = 8;
    localparam int NUM_PRESSES    = 20;
    localparam int HOLD_CYCLES    = 40;
    localparam int GAME_CYCLES    = 62 * bomb_pkg::CLK_PER_SEC;
    localparam int GAME_SECONDS   = 60;                  // Ticks from 1:00 down to 0:00
    localparam int TIMEOUT_CYCLES =
        7 * (NUM_PRESSES * (PRESS_CYCLES + MAX_GAP) + GAME_CYCLES + HOLD_CYCLES);

    logic                  clk = 1'b0;
    logic                  nrst;
    bomb_pkg::button_t     button_raw;
    bomb_pkg::game_state_t game_state;
    bomb_pkg::lives_t      lives;
    bomb_pkg::button_t     hint;
    bomb_pkg::min_t        cnt_min;
    bomb_pkg::sec_ten_t    cnt_sec_ten;
    bomb_pkg::sec_one_t    cnt_sec_one;

    bomb_pkg::min_t        prev_min = bomb_pkg::START_MIN;
    bomb_pkg::sec_ten_t    prev_sec_ten = bomb_pkg::START_SEC_TEN;
    bomb_pkg::sec_one_t    prev_sec_one = bomb_pkg::START_SEC_ONE;
    logic [9:0]            expected_time;
    int                    tick_count = 0;

    bomb_game_top bomb_game_top_inst (
        .clk         (clk),
        .nrst        (nrst),
        .button_raw  (button_raw),
        .game_state  (game_state),
        .lives       (lives),
        .hint        (hint),
        .cnt_min     (cnt_min),
        .cnt_sec_ten (cnt_sec_ten),
        .cnt_sec_one (cnt_sec_one)
    );

    always #20 clk = ~clk;                               // Period of 40

    // --------------------
    // Reference functions
    // --------------------

    // Time one game second later, packed as minutes, tens and ones
    function automatic logic [9:0] next_time(input bomb_pkg::min_t m,
                                             input bomb_pkg::sec_ten_t t,
                                             input bomb_pkg::sec_one_t o);
        bomb_pkg::min_t     m_n;
        bomb_pkg::sec_ten_t t_n;
        bomb_pkg::sec_one_t o_n;
        m_n = m;
        t_n = t;
        o_n = o;
        if (m == 3'd0 && t == 3'd0 && o == 4'd0) begin
            o_n = 4'd0;                                  // Stays at 0:00
        end else if (o != 4'd0) begin
            o_n = o - 4'd1;
        end else if (t != 3'd0) begin
            t_n = t - 3'd1;
            o_n = 4'd9;
        end else begin
            m_n = m - 3'd1;
            t_n = 3'd5;
            o_n = 4'd9;
        end
        return {m_n, t_n, o_n};
    endfunction

    function automatic bomb_pkg::lives_t expected_lives_after_error(input bomb_pkg::lives_t l);
        return l - 2'd1;                                 // One life per wrong arrow
    endfunction

    function automatic bomb_pkg::button_t arrow_code(input int idx);
        case (idx)
            0:       return bomb_pkg::BTN_UP;
            1:       return bomb_pkg::BTN_RIGHT;
            2:       return bomb_pkg::BTN_DOWN;
            default: return bomb_pkg::BTN_LEFT;
        endcase
    endfunction

    function automatic bomb_pkg::button_t pick_wrong_arrow(input bomb_pkg::button_t wanted);
        int                idx;
        bomb_pkg::button_t arrow;
        idx   = $urandom % 4;
        arrow = arrow_code(idx);
        if (arrow == wanted) begin
            arrow = arrow_code((idx + 1) % 4);
        end
        return arrow;
    endfunction

    // --------------------
    // Compare tasks
    // --------------------

    task automatic fail_run(input string msg);
        $display("FAILED at time %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_state(input bomb_pkg::game_state_t exp);
        if (game_state !== exp) begin
            fail_run($sformatf("state is %s, expected %s", game_state.name(), exp.name()));
        end
    endtask

    task automatic check_lives(input bomb_pkg::lives_t exp);
        if (lives !== exp) begin
            fail_run($sformatf("lives is %0d, expected %0d", lives, exp));
        end
    endtask

    task automatic check_hint(input bomb_pkg::button_t exp);
        if (hint !== exp) begin
            fail_run($sformatf("hint is %b, expected %b", hint, exp));
        end
    endtask

    task automatic check_time(input bomb_pkg::min_t m, input bomb_pkg::sec_ten_t t,
                              input bomb_pkg::sec_one_t o);
        if (cnt_min !== m || cnt_sec_ten !== t || cnt_sec_one !== o) begin
            fail_run($sformatf("time is %0d:%0d%0d, expected %0d:%0d%0d",
                               cnt_min, cnt_sec_ten, cnt_sec_one, m, t, o));
        end
    endtask

    // --------------------
    // Stimulus tasks
    // --------------------

    task automatic hold_buttons(input bomb_pkg::button_t code, input int cycles);
        button_raw = code;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic press_button(input bomb_pkg::button_t code);
        hold_buttons(code, 6);
        hold_buttons(bomb_pkg::BTN_NONE, 6);             // Strobe, judge and FSM have settled
    endtask

    task automatic idle_gap();
        repeat ($urandom % MAX_GAP) @(negedge clk);
    endtask

    task automatic wait_for_state(input bomb_pkg::game_state_t want, input int max_cycles);
        int waited;
        waited = 0;
        while (game_state != want && waited < max_cycles) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (game_state != want) begin
            $display("Gave up at time %0t after %0d cycles waiting for state %s",
                     $time, max_cycles, want.name());
            $display("Simulation failed");
            $fatal(1, "State not reached");
        end
    endtask

    // Every timer change in PLAY must be exactly one second down
    always @(negedge clk) begin
        if (nrst && game_state == bomb_pkg::PLAY &&
            {cnt_min, cnt_sec_ten, cnt_sec_one} != {prev_min, prev_sec_ten, prev_sec_one}) begin
            expected_time = next_time(prev_min, prev_sec_ten, prev_sec_one);
            check_time(expected_time[9:7], expected_time[6:4], expected_time[3:0]);
            tick_count = tick_count + 1;
        end
        prev_min     = cnt_min;
        prev_sec_ten = cnt_sec_ten;
        prev_sec_one = cnt_sec_one;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout expired after %0d clock cycles before the tests finished",
                 TIMEOUT_CYCLES);
        $display("Simulation failed");
        $fatal(1, "Watchdog stop");
    end

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        bomb_pkg::lives_t  exp_lives;
        bomb_pkg::button_t first_hint;
        int                ticks_at_start;
        void'($urandom(32'hd566c293));
        nrst       = 1'b0;
        button_raw = bomb_pkg::BTN_NONE;
        repeat (3) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);

        check_state(bomb_pkg::MENU);                     // Idle menu after reset
        check_lives(2'd0);
        check_hint(bomb_pkg::BTN_NONE);
        check_time(bomb_pkg::START_MIN, bomb_pkg::START_SEC_TEN, bomb_pkg::START_SEC_ONE);
        press_button(bomb_pkg::BTN_UP);
        check_state(bomb_pkg::MENU);
        press_button(bomb_pkg::BTN_BACK);
        check_state(bomb_pkg::MENU);
        hold_buttons(bomb_pkg::BTN_SELECT | bomb_pkg::BTN_UP, 6);
        hold_buttons(bomb_pkg::BTN_SELECT, HOLD_CYCLES / 2);     // No edge from idle
        hold_buttons(bomb_pkg::BTN_NONE, 6);
        check_state(bomb_pkg::MENU);
        check_lives(2'd0);

        press_button(bomb_pkg::BTN_SELECT);              // First game, lost on errors
        check_state(bomb_pkg::PLAY);
        check_lives(bomb_pkg::START_LIVES);
        if (!(hint inside {bomb_pkg::BTN_UP, bomb_pkg::BTN_RIGHT,
                           bomb_pkg::BTN_DOWN, bomb_pkg::BTN_LEFT})) begin
            fail_run($sformatf("hint %b is not an arrow", hint));
        end
        check_time(bomb_pkg::START_MIN, bomb_pkg::START_SEC_TEN, bomb_pkg::START_SEC_ONE);
        exp_lives = bomb_pkg::START_LIVES;
        repeat (3) begin
            idle_gap();
            press_button(pick_wrong_arrow(hint));
            exp_lives = expected_lives_after_error(exp_lives);
            check_lives(exp_lives);
            if (exp_lives != 2'd0) begin
                check_state(bomb_pkg::PLAY);
            end
        end
        check_state(bomb_pkg::LOST);
        check_hint(bomb_pkg::BTN_NONE);
        press_button(bomb_pkg::BTN_SELECT);
        check_state(bomb_pkg::MENU);
        check_time(bomb_pkg::START_MIN, bomb_pkg::START_SEC_TEN, bomb_pkg::START_SEC_ONE);

        press_button(bomb_pkg::BTN_SELECT);              // Second game, BACK then a win
        check_state(bomb_pkg::PLAY);
        first_hint = hint;
        repeat (2) begin
            idle_gap();
            press_button(hint);
            check_state(bomb_pkg::PLAY);
            check_lives(bomb_pkg::START_LIVES);
        end
        press_button(bomb_pkg::BTN_BACK);
        check_hint(first_hint);
        check_lives(bomb_pkg::START_LIVES);
        for (int i = 0; i < bomb_pkg::PUZZLE_LEN; i++) begin
            idle_gap();
            press_button(hint);
            if (i < bomb_pkg::PUZZLE_LEN - 1) begin
                check_state(bomb_pkg::PLAY);
            end
        end
        check_state(bomb_pkg::WON);
        check_hint(bomb_pkg::BTN_NONE);
        check_lives(bomb_pkg::START_LIVES);
        press_button(bomb_pkg::BTN_SELECT);
        check_state(bomb_pkg::MENU);

        press_button(bomb_pkg::BTN_SELECT);              // Third game, left to time out
        check_state(bomb_pkg::PLAY);
        ticks_at_start = tick_count;
        wait_for_state(bomb_pkg::LOST, GAME_CYCLES);
        check_time(3'd0, 3'd0, 4'd0);
        check_lives(bomb_pkg::START_LIVES);
        if (tick_count - ticks_at_start != GAME_SECONDS) begin
            fail_run($sformatf("saw %0d timer steps, expected %0d",
                               tick_count - ticks_at_start, GAME_SECONDS));
        end
        @(negedge clk);
        // Leaving PLAY raises timer_clear and the start time comes back
        check_time(bomb_pkg::START_MIN, bomb_pkg::START_SEC_TEN, bomb_pkg::START_SEC_ONE);
        press_button(bomb_pkg::BTN_SELECT);
        check_state(bomb_pkg::MENU);
        check_time(bomb_pkg::START_MIN, bomb_pkg::START_SEC_TEN, bomb_pkg::START_SEC_ONE);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- src/bomb_game_top.sv
module bomb_game_top (
    input  logic                  clk,
    input  logic                  nrst,
    input  bomb_pkg::button_t     button_raw,
    output bomb_pkg::game_state_t game_state,
    output bomb_pkg::lives_t      lives,
    output bomb_pkg::button_t     hint,
    output bomb_pkg::min_t        cnt_min,
    output bomb_pkg::sec_ten_t    cnt_sec_ten,
    output bomb_pkg::sec_one_t    cnt_sec_one
);

    logic              strobe;
    bomb_pkg::button_t button;
    logic              timer_clear;
    logic              activate_rand;
    bomb_pkg::seed_t   seed;
    logic              error;
    logic              game_clear;

    button_sync button_sync_inst (
        .clk        (clk),
        .nrst       (nrst),
        .button_raw (button_raw),
        .strobe     (strobe),
        .button     (button)
    );

    countdown_timer countdown_timer_inst (
        .clk         (clk),
        .nrst        (nrst),
        .timer_clear (timer_clear),
        .cnt_min     (cnt_min),
        .cnt_sec_ten (cnt_sec_ten),
        .cnt_sec_one (cnt_sec_one)
    );

    lfsr_rand lfsr_rand_inst (
        .clk           (clk),
        .nrst          (nrst),
        .activate_rand (activate_rand),
        .seed          (seed)
    );

    arrow_puzzle arrow_puzzle_inst (
        .clk        (clk),
        .nrst       (nrst),
        .game_state (game_state),
        .seed       (seed),
        .strobe     (strobe),
        .button     (button),
        .hint       (hint),
        .error      (error),
        .game_clear (game_clear)
    );

    game_control_fsm game_control_fsm_inst (
        .clk           (clk),
        .nrst          (nrst),
        .strobe        (strobe),
        .button        (button),
        .error         (error),
        .game_clear    (game_clear),
        .cnt_min       (cnt_min),
        .cnt_sec_ten   (cnt_sec_ten),
        .cnt_sec_one   (cnt_sec_one),
        .game_state    (game_state),
        .lives         (lives),
        .timer_clear   (timer_clear),
        .activate_rand (activate_rand)
    );

endmodule

//--- src/game_control_fsm.sv
module game_control_fsm (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  strobe,
    input  bomb_pkg::button_t     button,
    input  logic                  error,
    input  logic                  game_clear,
    input  bomb_pkg::min_t        cnt_min,
    input  bomb_pkg::sec_ten_t    cnt_sec_ten,
    input  bomb_pkg::sec_one_t    cnt_sec_one,
    output bomb_pkg::game_state_t game_state,
    output bomb_pkg::lives_t      lives,
    output logic                  timer_clear,
    output logic                  activate_rand
);

    bomb_pkg::game_state_t next_game_state;
    bomb_pkg::lives_t      next_lives;
    logic                  select_press;
    logic                  time_up;

    assign select_press = strobe && (button == bomb_pkg::BTN_SELECT);
    assign time_up      = (cnt_min == '0) && (cnt_sec_ten == '0) && (cnt_sec_one == '0);

    // --------------------
    // State and lives registers
    // --------------------

    always_ff @(posedge clk) begin
        if (!nrst) begin
            game_state <= bomb_pkg::MENU;
            lives      <= '0;
        end else begin
            game_state <= next_game_state;
            lives      <= next_lives;
        end
    end

    // --------------------
    // Next state logic
    // --------------------

    always_comb begin
        next_game_state = game_state;
        next_lives      = lives;
        activate_rand   = 1'b0;
        timer_clear     = 1'b1;                          // Timer only runs during play
        case (game_state)
            bomb_pkg::MENU: begin
                if (select_press) begin
                    next_game_state = bomb_pkg::PLAY;
                    next_lives      = bomb_pkg::START_LIVES;
                    activate_rand   = 1'b1;              // Grab a seed as the game starts
                end
            end
            bomb_pkg::PLAY: begin
                timer_clear = 1'b0;
                // A solved puzzle wins even if time runs out in the same cycle
                if (game_clear) begin
                    next_game_state = bomb_pkg::WON;
                end else if (time_up) begin
                    next_game_state = bomb_pkg::LOST;
                end else if (error) begin
                    next_lives = lives - 1'b1;
                    if (lives == bomb_pkg::lives_t'(1)) begin
                        next_game_state = bomb_pkg::LOST;    // Last life gone
                    end
                end
            end
            bomb_pkg::LOST,
            bomb_pkg::WON: begin
                if (select_press) begin
                    next_game_state = bomb_pkg::MENU;    // Lives keep their value
                end
            end
            default: begin
                next_game_state = bomb_pkg::MENU;
            end
        endcase
    end

endmodule

//--- src/arrow_puzzle.sv
module arrow_puzzle (
    input  logic                  clk,
    input  logic                  nrst,
    input  bomb_pkg::game_state_t game_state,
    input  bomb_pkg::seed_t       seed,
    input  logic                  strobe,
    input  bomb_pkg::button_t     button,
    output bomb_pkg::button_t     hint,
    output logic                  error,
    output logic                  game_clear
);

    bomb_pkg::step_t step;
    logic            done;
    logic            active;
    logic [1:0]      arrow_sel;

    assign active    = (game_state == bomb_pkg::PLAY) && !done;
    assign arrow_sel = seed[2*step +: 2];                // Two seed bits per step

    // --------------------
    // Wanted arrow
    // --------------------

    always_comb begin
        hint = bomb_pkg::BTN_NONE;
        if (active) begin
            case (arrow_sel)
                2'd0:    hint = bomb_pkg::BTN_UP;
                2'd1:    hint = bomb_pkg::BTN_RIGHT;
                2'd2:    hint = bomb_pkg::BTN_DOWN;
                default: hint = bomb_pkg::BTN_LEFT;
            endcase
        end
    end

    // --------------------
    // Press judging
    // --------------------

    always_ff @(posedge clk) begin
        if (!nrst) begin
            step       <= '0;
            done       <= 1'b0;
            error      <= 1'b0;
            game_clear <= 1'b0;
        end else begin
            error      <= 1'b0;                          // Both outputs are single-cycle pulses
            game_clear <= 1'b0;
            if (game_state != bomb_pkg::PLAY) begin
                step <= '0;                              // Fresh puzzle for the next game
                done <= 1'b0;
            end else if (strobe && active) begin
                if (button == bomb_pkg::BTN_BACK) begin
                    step <= '0;                          // Start over, no life lost
                end else if (button == bomb_pkg::BTN_SELECT) begin
                    step <= step;
                end else if (button == hint) begin
                    if (step == bomb_pkg::step_t'(bomb_pkg::PUZZLE_LEN - 1)) begin
                        step       <= '0;
                        done       <= 1'b1;              // Blank the hint until the next game
                        game_clear <= 1'b1;
                    end else begin
                        step <= step + 1'b1;
                    end
                end else begin
                    error <= 1'b1;                       // Wrong arrow keeps the step
                end
            end
        end
    end

endmodule

//--- src/lfsr_rand.sv
module lfsr_rand (
    input  logic            clk,
    input  logic            nrst,
    input  logic            activate_rand,
    output bomb_pkg::seed_t seed
);

    bomb_pkg::lfsr_t lfsr;
    logic            feedback;

    // --------------------
    // Free-running LFSR
    // --------------------

    // Taps 16, 14, 13 and 11 give a maximal length sequence
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk) begin
        if (!nrst) begin
            lfsr <= bomb_pkg::LFSR_RESET;
        end else begin
            lfsr <= {lfsr[14:0], feedback};              // Shifts every cycle, even when idle
        end
    end

    // --------------------
    // Seed capture
    // --------------------

    always_ff @(posedge clk) begin
        if (!nrst) begin
            seed <= '0;
        end else if (activate_rand) begin
            seed <= lfsr[7:0];                           // Press timing picks the sequence
        end
    end

endmodule

//--- src/countdown_timer.sv
module countdown_timer (
    input  logic               clk,
    input  logic               nrst,
    input  logic               timer_clear,
    output bomb_pkg::min_t     cnt_min,
    output bomb_pkg::sec_ten_t cnt_sec_ten,
    output bomb_pkg::sec_one_t cnt_sec_one
);

    bomb_pkg::presc_t presc;
    logic             sec_tick;
    logic             at_zero;

    // --------------------
    // Second prescaler
    // --------------------

    assign sec_tick = (presc == bomb_pkg::presc_t'(bomb_pkg::CLK_PER_SEC - 1));

    always_ff @(posedge clk) begin
        if (!nrst) begin
            presc <= '0;
        end else if (timer_clear) begin
            presc <= '0;                                 // Next game gets a full first second
        end else if (sec_tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // --------------------
    // Digit countdown
    // --------------------

    assign at_zero = (cnt_min == '0) && (cnt_sec_ten == '0) && (cnt_sec_one == '0);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            cnt_min     <= bomb_pkg::START_MIN;
            cnt_sec_ten <= bomb_pkg::START_SEC_TEN;
            cnt_sec_one <= bomb_pkg::START_SEC_ONE;
        end else if (timer_clear) begin
            cnt_min     <= bomb_pkg::START_MIN;          // Reload the start time
            cnt_sec_ten <= bomb_pkg::START_SEC_TEN;
            cnt_sec_one <= bomb_pkg::START_SEC_ONE;
        end else if (sec_tick && !at_zero) begin
            if (cnt_sec_one != '0) begin
                cnt_sec_one <= cnt_sec_one - 1'b1;
            end else if (cnt_sec_ten != '0) begin
                cnt_sec_one <= bomb_pkg::SEC_ONE_MAX;    // Borrow from the tens
                cnt_sec_ten <= cnt_sec_ten - 1'b1;
            end else begin
                // Both second digits are zero, so the borrow reaches the minutes
                cnt_sec_one <= bomb_pkg::SEC_ONE_MAX;
                cnt_sec_ten <= bomb_pkg::SEC_TEN_MAX;
                cnt_min     <= cnt_min - 1'b1;
            end
        end
    end

endmodule

//--- src/button_sync.sv
module button_sync (
    input  logic              clk,
    input  logic              nrst,
    input  bomb_pkg::button_t button_raw,
    output logic              strobe,
    output bomb_pkg::button_t button
);

    bomb_pkg::button_t sync_ff1;
    bomb_pkg::button_t sync_ff2;
    bomb_pkg::button_t btn_prev;
    logic              press;

    // --------------------
    // Two-flop synchronizer
    // --------------------

    always_ff @(posedge clk) begin
        if (!nrst) begin
            sync_ff1 <= bomb_pkg::BTN_NONE;
            sync_ff2 <= bomb_pkg::BTN_NONE;
        end else begin
            sync_ff1 <= button_raw;                      // May go metastable
            sync_ff2 <= sync_ff1;                        // Settled copy
        end
    end

    // --------------------
    // Press detection
    // --------------------

    always_ff @(posedge clk) begin
        if (!nrst) begin
            btn_prev <= bomb_pkg::BTN_NONE;
        end else begin
            btn_prev <= sync_ff2;                        // Value seen one cycle earlier
        end
    end

    // A new press leaves the idle level with exactly one button down
    assign press = (btn_prev == bomb_pkg::BTN_NONE) && $onehot(sync_ff2);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            strobe <= 1'b0;
            button <= bomb_pkg::BTN_NONE;
        end else begin
            strobe <= press;                             // Single cycle, a held level has no edge
            if (press) begin
                button <= sync_ff2;                      // Stays put until the next press
            end
        end
    end

endmodule

//--- src/bomb_pkg.sv
package bomb_pkg;

    // --------------------
    // Buttons
    // --------------------

    typedef logic [5:0] button_t;                        // One-hot button code

    localparam button_t BTN_SELECT = 6'b000001;
    localparam button_t BTN_UP     = 6'b000010;
    localparam button_t BTN_RIGHT  = 6'b000100;
    localparam button_t BTN_DOWN   = 6'b001000;
    localparam button_t BTN_LEFT   = 6'b010000;
    localparam button_t BTN_BACK   = 6'b100000;
    localparam button_t BTN_NONE   = 6'b000000;          // No button pressed

    // --------------------
    // Game state and lives
    // --------------------

    typedef enum logic [2:0] {
        MENU = 3'd0,
        PLAY = 3'd1,
        LOST = 3'd2,
        WON  = 3'd3
    } game_state_t;

    typedef logic [1:0] lives_t;

    localparam lives_t START_LIVES = 2'd3;

    // --------------------
    // Countdown timer
    // --------------------

    typedef logic [2:0] min_t;                           // Minutes digit
    typedef logic [2:0] sec_ten_t;                       // Tens of seconds, 0 to 5
    typedef logic [3:0] sec_one_t;                       // Ones of seconds, 0 to 9

    localparam min_t     START_MIN     = 3'd1;           // Game starts at 1:00
    localparam sec_ten_t START_SEC_TEN = 3'd0;
    localparam sec_one_t START_SEC_ONE = 4'd0;
    localparam sec_ten_t SEC_TEN_MAX   = 3'd5;           // Reload value on a borrow
    localparam sec_one_t SEC_ONE_MAX   = 4'd9;

    localparam int CLK_PER_SEC = 20;                     // Kept short so a game fits in sim
    localparam int PRESC_W     = $clog2(CLK_PER_SEC);

    typedef logic [PRESC_W-1:0] presc_t;

    // --------------------
    // Arrow puzzle and random source
    // --------------------

    typedef logic [15:0] lfsr_t;
    typedef logic [7:0]  seed_t;                         // Two bits per arrow step
    typedef logic [1:0]  step_t;

    localparam int    PUZZLE_LEN = 4;                    // Arrows to enter for a win
    localparam lfsr_t LFSR_RESET = 16'hACE1;             // Any nonzero value works

endpackage
